// File: compile.f
source/copy_pkg.sv
source/addr_gen.sv
source/word_ram.sv
source/copy_ctrl.sv
source/copy_engine.sv
dv/copy_engine_chk.sv
dv/copy_engine_tb.sv

// File: dv/copy_engine_chk.sv
`default_nettype none

module copy_engine_chk (
   input logic                 clk_i,
   input logic                 rst_i,
   input logic                 start_i,
   input logic                 pause_i,
   input logic                 host_sel_i,  // High only in IDLE.
   input logic                 run_i,
   input logic                 ram_we_i,
   input logic                 rd_valid_i,
   input copy_pkg::byte_addr_t rd_addr_i,
   input logic                 busy_i,
   input logic                 done_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // ********************
   // Status timing
   // ********************

   done_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      done_i |=> !done_i) else $error("done_o lasted more than one cycle.");

   busy_falls_with_done: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(done_i) |-> $fell(busy_i)) else $error("busy_o did not fall as done_o rose.");

   // Start taken in IDLE shows up as busy on the next edge.
   busy_after_start: assert property (@(posedge clk_i) disable iff (rst_i)
      (host_sel_i && start_i) |=> busy_i) else $error("busy_o missing after start_i.");

   // Back to idle after done, even with start_i high.
   idle_after_done: assert property (@(posedge clk_i) disable iff (rst_i)
      done_i |=> !busy_i) else $error("busy_o high right after done_o.");

   // ********************
   // Reset and stalls
   // ********************

   reset_quiet: assert property (@(posedge clk_i)
      rst_i |-> (!busy_i && !done_i && !run_i && !rd_valid_i && !ram_we_i))
      else $error("Control outputs active during reset.");

   read_held_on_pause: assert property (@(posedge clk_i) disable iff (rst_i)
      (pause_i && rd_valid_i && !host_sel_i) |=> $stable(rd_addr_i))
      else $error("Read address moved while paused.");

endmodule

bind copy_engine copy_engine_chk u_chk (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .start_i    (start_i),
   .pause_i    (pause_i),
   .host_sel_i (host_sel),
   .run_i      (run),
   .ram_we_i   (ram_we),
   .rd_valid_i (rd_valid),
   .rd_addr_i  (rd_addr),
   .busy_i     (busy_o),
   .done_i     (done_o)
);

`default_nettype wire

// File: dv/copy_engine_tb.sv
`default_nettype none

module copy_engine_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import copy_pkg::*;

   localparam int RESET_CYCLES = 5;
   localparam int MEM_ROWS     = 1 << WORD_IDX_W;
   localparam int NUM_COPIES   = 6;
   localparam int MAX_COUNT    = 32;
   localparam int MAX_DELAY    = 15;
   localparam int PAUSE_BUDGET = 24; // Paused cycles allowed per copy.

   // Worst case for one copy, then host fill and one full readback per copy.
   localparam int COPY_CYCLES = MAX_DELAY + 2 * MAX_COUNT + PAUSE_BUDGET + 10;
   localparam int HOST_CYCLES = (MEM_ROWS + 1) + NUM_COPIES * 2 * MEM_ROWS;
   localparam int CYCLE_LIMIT = RESET_CYCLES + HOST_CYCLES + NUM_COPIES * COPY_CYCLES + 10;

   logic      clk_i        = 1'b0;
   logic      rst_i        = 1'b1;
   logic      start_i      = 1'b0;
   copy_cfg_t cfg_i        = '0;
   logic      pause_i      = 1'b0;
   logic      host_we_i    = 1'b0;
   word_idx_t host_idx_i   = '0;
   word_t     host_wdata_i = '0;
   word_t     host_rdata_o;
   logic      busy_o;
   logic      done_o;

   word_t       shadow [MEM_ROWS]; // Expected RAM contents.
   logic [31:0] lcg_state   = 32'd98;
   int          cycle_count = 0;
   bit          verdict_done = 1'b0;

   copy_engine DUT (.*);

   always #20 clk_i = ~clk_i;

   // ********************
   // Helpers
   // ********************

   function automatic int lcg_draw();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return int'({16'h0000, lcg_state[31:16]}); // Upper bits, better spread.
   endfunction

   function automatic word_t random_word();
      int hi;
      int lo;
      hi = lcg_draw();
      lo = lcg_draw();
      return {hi[15:0], lo[15:0]};
   endfunction

   task automatic abort_run();
      verdict_done = 1'b1;
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at the first error.");
   endtask

   // Regions sit in opposite halves of the RAM, so they never overlap.
   function automatic copy_cfg_t make_cfg(input bit backward);
      copy_cfg_t cfg;
      int        cnt;
      int        src_row;
      int        dst_row;
      int        tmp;
      cnt     = 1 + lcg_draw() % MAX_COUNT;
      src_row = lcg_draw() % (MEM_ROWS / 2 - cnt + 1);
      dst_row = MEM_ROWS / 2 + lcg_draw() % (MEM_ROWS / 2 - cnt + 1);
      if (lcg_draw() % 2 == 1) begin
         tmp     = src_row;
         src_row = dst_row;
         dst_row = tmp;
      end
      if (backward) begin
         src_row  = src_row + cnt - 1; // Walk down from the top of each region.
         dst_row  = dst_row + cnt - 1;
         cfg.incr = word_incr_t'(-1);
      end else begin
         cfg.incr = word_incr_t'(1);
      end
      cfg.src_start = byte_addr_t'(src_row << OFFSET_W);
      cfg.dst_start = byte_addr_t'(dst_row << OFFSET_W);
      cfg.count     = count_t'(cnt);
      cfg.delay     = delay_t'(lcg_draw() % (MAX_DELAY + 1));
      return cfg;
   endfunction

   // Dst word k takes the old src word k.
   task automatic apply_model(input copy_cfg_t cfg);
      word_t     moved [$];
      word_idx_t src_row;
      word_idx_t dst_row;
      int        step;
      step = int'($signed(cfg.incr));
      for (int k = 0; k < int'(cfg.count); k++) begin
         src_row = cfg.src_start[ADDR_W-1:OFFSET_W] + word_idx_t'(k * step);
         moved.push_back(shadow[src_row]);
      end
      for (int k = 0; k < int'(cfg.count); k++) begin
         dst_row = cfg.dst_start[ADDR_W-1:OFFSET_W] + word_idx_t'(k * step);
         shadow[dst_row] = moved.pop_front();
      end
   endtask

   // ********************
   // Host traffic
   // ********************

   task automatic fill_memory();
      word_t w;
      for (int r = 0; r < MEM_ROWS; r++) begin
         w         = random_word();
         shadow[r] = w;
         @(posedge clk_i);
         host_we_i    <= 1'b1;
         host_idx_i   <= word_idx_t'(r);
         host_wdata_i <= w;
      end
      @(posedge clk_i);
      host_we_i <= 1'b0;
   endtask

   task automatic check_memory();
      for (int r = 0; r < MEM_ROWS; r++) begin
         @(posedge clk_i);
         host_idx_i <= word_idx_t'(r);
         @(posedge clk_i);
         @(negedge clk_i); // Registered read has settled.
         assert (host_rdata_o === shadow[r]) else begin
            $display("FAILED at %0t: host_rdata_o row %0d expected %08h actual %08h",
                     $time, r, shadow[r], host_rdata_o);
            abort_run();
         end
      end
   endtask

   // Noisy runs add pause pulses, host writes and start strobes while busy.
   task automatic run_copy(input copy_cfg_t cfg, input bit noisy);
      int busy_cycles;
      int pause_left;
      int r;
      busy_cycles = 0;
      pause_left  = PAUSE_BUDGET;
      @(posedge clk_i);
      cfg_i   <= cfg;
      start_i <= 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
      @(negedge clk_i);
      while (done_o !== 1'b1) begin
         if (busy_o === 1'b1) begin
            busy_cycles++;
         end
         @(posedge clk_i);
         if (noisy) begin
            r = lcg_draw();
            pause_i      <= (r % 4 == 0) && (pause_left > 0);
            pause_left   = (r % 4 == 0) ? pause_left - 1 : pause_left;
            host_we_i    <= (r % 3 == 0);
            host_idx_i   <= word_idx_t'(lcg_draw());
            host_wdata_i <= random_word();
            start_i      <= (r % 8 == 1);
         end
         @(negedge clk_i);
      end
      @(posedge clk_i);
      pause_i   <= 1'b0;
      host_we_i <= 1'b0;
      start_i   <= 1'b0;
      assert (busy_cycles >= int'(cfg.delay) + int'(cfg.count)) else begin
         $display("FAILED at %0t: busy_o cycles expected at least %0d actual %0d",
                  $time, int'(cfg.delay) + int'(cfg.count), busy_cycles);
         abort_run();
      end
   endtask

   // ********************
   // Main sequence
   // ********************

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the copy engine stopped responding.",
                  cycle_count);
         abort_run();
      end
   end

   initial begin
      copy_cfg_t cfg;
      repeat (RESET_CYCLES) @(posedge clk_i);
      rst_i <= 1'b0;
      fill_memory();
      for (int i = 0; i < NUM_COPIES; i++) begin
         cfg = make_cfg(i % 3 == 1);   // Every third copy runs backward.
         run_copy(cfg, i % 3 == 2);
         apply_model(cfg);
         check_memory();
      end
      verdict_done = 1'b1;
      $display("TEST RESULT: PASS");
      $finish;
   end

   // Run cut short by a failing assertion in the checker.
   final begin
      if (!verdict_done) begin
         $display("Simulation ended before the test sequence completed.");
         $display("TEST RESULT: FAIL");
      end
   end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the copy engine testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=copy_engine_sim

verilator --binary --timing --assert -f compile.f --top-module copy_engine_tb -o "$SIM"
if [ $? -ne 0 ]; then
   echo "Verilator build failed."
   exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status."
   exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
   exit 0
fi
echo "No pass message found in $LOG."
exit 1

// File: source/addr_gen.sv
`default_nettype none

module addr_gen (
   input  logic                 clk_i,
   input  logic                 rst_i,

   input  logic                 run_i,    // One-cycle launch.

   // Job settings.
   input  copy_pkg::byte_addr_t start_i,
   input  copy_pkg::word_incr_t incr_i,
   input  copy_pkg::count_t     count_i,
   input  copy_pkg::delay_t     delay_i,

   // Address stream.
   input  logic                 ready_i,
   output logic                 valid_o,
   output copy_pkg::byte_addr_t addr_o,

   output logic                 done_o    // Held until the next run.
);
   import copy_pkg::*;

   delay_t wait_q;
   count_t idx_q;
   logic   fire;
   logic   last;

   assign fire = valid_o & ready_i;

   // Index of the word currently offered.
   assign last = (idx_q == count_t'(count_i - 1'b1));

   // ********************
   // Sequencing
   // ********************

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wait_q  <= '0;
         idx_q   <= '0;
         valid_o <= 1'b0;
         done_o  <= 1'b0;
      end else if (run_i) begin
         wait_q  <= delay_i;
         idx_q   <= '0;
         valid_o <= (delay_i == '0); // No delay, offer at once.
         done_o  <= 1'b0;
      end else if (wait_q != '0) begin
         wait_q <= wait_q - 1'b1;
         // Valid rises as the countdown expires.
         valid_o <= (wait_q == delay_t'(1));
      end else if (fire) begin
         if (last) begin
            valid_o <= 1'b0;
            done_o  <= 1'b1;
         end else begin
            idx_q <= idx_q + 1'b1;
         end
      end
   end

   // ********************
   // Address
   // ********************

   // Word step becomes a byte step.
   always_ff @(posedge clk_i) begin
      if (run_i) begin
         addr_o <= start_i;
      end else if (fire && !last) begin
         addr_o <= addr_o + byte_addr_t'(incr_i <<< OFFSET_W);
      end
   end

endmodule

`default_nettype wire

// File: source/copy_ctrl.sv
`default_nettype none

module copy_ctrl (
   input  logic clk_i,
   input  logic rst_i,

   input  logic start_i,      // Strobe.
   input  logic pause_i,      // Level, stalls the read side.
   input  logic host_we_i,

   // Generator status.
   input  logic rd_valid_i,
   input  logic wr_valid_i,
   input  logic wr_done_i,

   // Generator control.
   output logic run_o,
   output logic rd_ready_o,
   output logic wr_ready_o,

   // RAM side.
   output logic data_valid_o, // RAM read data belongs to a read fire.
   output logic ram_we_o,
   output logic host_sel_o,   // Host owns the RAM ports.

   output logic busy_o,
   output logic done_o
);
   import copy_pkg::*;

   ctrl_state_t state_q;
   ctrl_state_t state_d;
   logic        data_valid_q;
   logic        rd_fire;

   // ********************
   // State machine
   // ********************

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (start_i) begin
               state_d = LAUNCH;
            end
         end
         LAUNCH: begin
            state_d = COPY; // Run pulse goes out here.
         end
         COPY: begin
            // Last write has landed.
            if (wr_done_i) begin
               state_d = FINISH;
            end
         end
         FINISH: begin
            state_d = IDLE;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // ********************
   // Read side
   // ********************

   assign run_o      = (state_q == LAUNCH);
   assign rd_ready_o = (state_q == COPY) & ~pause_i;
   assign rd_fire    = rd_valid_i & rd_ready_o;

   // RAM data shows up one cycle after the read fire.
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         data_valid_q <= 1'b0;
      end else begin
         data_valid_q <= rd_fire;
      end
   end

   assign data_valid_o = data_valid_q;

   // ********************
   // Write side
   // ********************

   // Write address advances only with a word in hand.
   assign wr_ready_o = data_valid_q;

   assign host_sel_o = (state_q == IDLE);

   // Host writes during a copy are dropped.
   assign ram_we_o = host_sel_o ? host_we_i : (wr_valid_i & data_valid_q);

   // ********************
   // Status
   // ********************

   assign busy_o = (state_q == LAUNCH) | (state_q == COPY);
   assign done_o = (state_q == FINISH); // One cycle.

endmodule

`default_nettype wire

// File: source/copy_engine.sv
`default_nettype none

module copy_engine (
   input  logic                clk_i,
   input  logic                rst_i,

   // Job control.
   input  logic                start_i,      // Sampled only when idle.
   input  copy_pkg::copy_cfg_t cfg_i,
   input  logic                pause_i,

   // Host port, active while idle.
   input  logic                host_we_i,
   input  copy_pkg::word_idx_t host_idx_i,
   input  copy_pkg::word_t     host_wdata_i,
   output copy_pkg::word_t     host_rdata_o,

   // Status.
   output logic                busy_o,
   output logic                done_o
);
   import copy_pkg::*;

   // ********************
   // Internal nets
   // ********************

   logic       run;

   logic       rd_valid;
   logic       rd_ready;
   byte_addr_t rd_addr;

   logic       wr_valid;
   logic       wr_ready;
   byte_addr_t wr_addr;
   logic       wr_done;

   logic       ram_we;
   logic       host_sel;

   word_idx_t  ram_rd_idx;
   word_idx_t  ram_wr_idx;
   word_t      ram_wdata;
   word_t      ram_rdata;

   // ********************
   // Control
   // ********************

   copy_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (start_i),
      .pause_i      (pause_i),
      .host_we_i    (host_we_i),
      .rd_valid_i   (rd_valid),
      .wr_valid_i   (wr_valid),
      .wr_done_i    (wr_done),
      .run_o        (run),
      .rd_ready_o   (rd_ready),
      .wr_ready_o   (wr_ready),
      .data_valid_o (),
      .ram_we_o     (ram_we),
      .host_sel_o   (host_sel),
      .busy_o       (busy_o),
      .done_o       (done_o)
   );

   // ********************
   // Generators
   // ********************

   // Source side, starts after the configured delay.
   addr_gen u_rd_gen (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .run_i   (run),
      .start_i (cfg_i.src_start),
      .incr_i  (cfg_i.incr),
      .count_i (cfg_i.count),
      .delay_i (cfg_i.delay),
      .ready_i (rd_ready),
      .valid_o (rd_valid),
      .addr_o  (rd_addr),
      .done_o  ()
   );

   // Destination side, paced by the read data.
   addr_gen u_wr_gen (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .run_i   (run),
      .start_i (cfg_i.dst_start),
      .incr_i  (cfg_i.incr),
      .count_i (cfg_i.count),
      .delay_i ('0),
      .ready_i (wr_ready),
      .valid_o (wr_valid),
      .addr_o  (wr_addr),
      .done_o  (wr_done)
   );

   // ********************
   // RAM port muxing
   // ********************

   // Byte addresses lose their offset bits to become rows.
   assign ram_rd_idx = host_sel ? host_idx_i : rd_addr[ADDR_W-1:OFFSET_W];
   assign ram_wr_idx = host_sel ? host_idx_i : wr_addr[ADDR_W-1:OFFSET_W];
   assign ram_wdata  = host_sel ? host_wdata_i : ram_rdata; // Copy loops back.

   word_ram u_ram (
      .clk_i    (clk_i),
      .we_i     (ram_we),
      .wr_idx_i (ram_wr_idx),
      .wdata_i  (ram_wdata),
      .rd_idx_i (ram_rd_idx),
      .rdata_o  (ram_rdata)
   );

   assign host_rdata_o = ram_rdata;

endmodule

`default_nettype wire

// File: source/copy_pkg.sv
`default_nettype none

package copy_pkg;

   // ********************
   // Widths
   // ********************

   localparam int ADDR_W     = 10; // Byte address space.
   localparam int DATA_W     = 32;
   localparam int OFFSET_W   = 2;  // Byte lanes within one word.
   localparam int COUNT_W    = 8;
   localparam int DELAY_W    = 8;
   localparam int WORD_IDX_W = 8;  // 256 rows.

   // ********************
   // Vector types
   // ********************

   typedef logic [ADDR_W-1:0] byte_addr_t;
   typedef logic [DATA_W-1:0] word_t;
   typedef logic [WORD_IDX_W-1:0] word_idx_t;

   // Step in words, scaled to bytes by the generator.
   typedef logic signed [ADDR_W-1:0] word_incr_t;

   typedef logic [COUNT_W-1:0] count_t; // Never zero.
   typedef logic [DELAY_W-1:0] delay_t;

   // Copy job, held stable while busy.
   typedef struct packed {
      byte_addr_t src_start;
      byte_addr_t dst_start;
      word_incr_t incr;   // Same step for both regions.
      count_t     count;
      delay_t     delay;  // Idle cycles before the first read.
   } copy_cfg_t;

   typedef enum logic [1:0] {
      IDLE,
      LAUNCH,
      COPY,
      FINISH
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/word_ram.sv
`default_nettype none

module word_ram (
   input  logic                clk_i,

   // Write port.
   input  logic                we_i,
   input  copy_pkg::word_idx_t wr_idx_i,
   input  copy_pkg::word_t     wdata_i,

   // Read port, one cycle of latency.
   input  copy_pkg::word_idx_t rd_idx_i,
   output copy_pkg::word_t     rdata_o
);
   import copy_pkg::*;

   // ********************
   // Storage
   // ********************

   // One row per word index.
   word_t mem [1 << WORD_IDX_W];

   // Synchronous write.
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[wr_idx_i] <= wdata_i;
      end
   end

   // ********************
   // Read
   // ********************

   // Registered read. A write to the same row on this edge is not
   // visible yet, so the old word comes out.
   always_ff @(posedge clk_i) begin
      rdata_o <= mem[rd_idx_i];
   end

endmodule

`default_nettype wire
